// ==== design/dp_reconfig_params.svh ====
// ***********************************************
// DisplayPort rate-change controller
// Shared widths and the APB register map
// ***********************************************

`ifndef DP_RECONFIG_PARAMS_SVH
`define DP_RECONFIG_PARAMS_SVH

// APB slave port
`define DP_APB_ADDR_W		4		// Byte address into the register block
`define DP_APB_DATA_W		32

// Register map, one word each
`define DP_REG_CTRL			4'h0	// mif_type and start
`define DP_REG_RATE			4'h4	// RX and TX link rate
`define DP_REG_STATUS		4'h8	// Read only

// Reconfiguration write port
`define DP_MIF_OFFSET_W		6		// PMA register offset
`define DP_MIF_DATA_W		16		// Value written at that offset
`define DP_MIF_INDEX_W		4		// Word position within one MIF list

`endif

// ==== design/dp_reconfig_pkg.sv ====
// ***********************************************
// DisplayPort rate-change controller
// MIF type and link-rate codes, status word layout
// ***********************************************

`default_nettype none

package dp_reconfig_pkg;

	// Which MIF list to walk
	typedef enum logic [2:0]
	{
		MIF_DUPLEX	= 3'd0,		// RX list then TX list
		MIF_CMU		= 3'd1,		// TX PLL
		MIF_RX		= 3'd2,
		MIF_TX		= 3'd3,
		MIF_ATX		= 3'd4		// No table for it
	} mif_type_e;

	// DP link rates, code 3 is not a rate
	typedef enum logic [1:0]
	{
		RATE_RBR	= 2'd0,		// 1.62 Gbps
		RATE_HBR	= 2'd1,		// 2.7 Gbps
		RATE_HBR2	= 2'd2		// 5.4 Gbps
	} link_rate_e;

	// STATUS register, low 12 bits
	typedef struct packed
	{
		logic [3:0]	word_count;	// Words accepted in the last run
		logic [4:0]	reserved;
		logic		error;		// Last start was refused
		logic		done;		// Last run completed
		logic		busy;		// Run in progress
	} reconfig_status_t;

endpackage

`default_nettype wire

// ==== design/dp_reconfig_ctrl_if.sv ====
// ***********************************************
// DisplayPort rate-change controller
// Control and status between APB regs and sequencer
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

interface dp_reconfig_ctrl_if;
	import dp_reconfig_pkg::*;

	logic				start;			// One cycle, on the APB access cycle
	mif_type_e			mif_type;		// List requested by the host
	link_rate_e			rx_link_rate;
	link_rate_e			tx_link_rate;
	reconfig_status_t	status;			// Sequencer state for readback

	// Register block side
	modport regs (
		output	start,
		output	mif_type,
		output	rx_link_rate,
		output	tx_link_rate,
		input	status
	);

	// Sequencer side
	modport seq (
		input	start,
		input	mif_type,
		input	rx_link_rate,
		input	tx_link_rate,
		output	status
	);

endinterface

`default_nettype wire

// ==== design/dp_mif_mappings.sv ====
// ***********************************************
// DisplayPort MIF word table
// Gives PMA offset, value and last-word flag for
// one word of the RX, TX or CMU list
// Word set differs per family and per link rate
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

`include "dp_reconfig_params.svh"

module dp_mif_mappings #(
	parameter DEVICE_FAMILY = "Stratix V"
)(
	input  wire dp_reconfig_pkg::mif_type_e		mif_type,
	input  wire dp_reconfig_pkg::link_rate_e	rx_link_rate,
	input  wire dp_reconfig_pkg::link_rate_e	tx_link_rate,
	input  wire [`DP_MIF_INDEX_W-1:0]			index,
	output logic [`DP_MIF_OFFSET_W-1:0]			offset,
	output logic [`DP_MIF_DATA_W-1:0]			value,
	output logic								done
);
	import dp_reconfig_pkg::*;

	link_rate_e									rate;	// Rate for the selected list
	logic [`DP_MIF_OFFSET_W+`DP_MIF_DATA_W:0]	row;	// {offset, value, done}

	// Per-rate value of one word
	function automatic logic [`DP_MIF_DATA_W-1:0] pick(
		input link_rate_e					r,
		input logic [`DP_MIF_DATA_W-1:0]	v_rbr,
		input logic [`DP_MIF_DATA_W-1:0]	v_hbr,
		input logic [`DP_MIF_DATA_W-1:0]	v_hbr2
	);
		case (r)
			RATE_RBR:	return v_rbr;
			RATE_HBR:	return v_hbr;
			RATE_HBR2:	return v_hbr2;
			default:	return '0;		// Code 3 maps to nothing
		endcase
	endfunction

	assign rate = (mif_type == MIF_RX) ? rx_link_rate : tx_link_rate;	// CMU runs at TX rate
	assign {offset, value, done} = row;

	// ***********************************************
	// Arria V table, shared by Cyclone V
	// ***********************************************
	if (DEVICE_FAMILY == "Arria V" || DEVICE_FAMILY == "Cyclone V")
	begin : g_arria_v
		always_comb
		begin
			row = '0;		// Unlisted type or index
			case ({mif_type, index})
				{MIF_RX, 4'd0}:		// PMA RX PLL word 1
					row = {6'h0e, pick(rate, 16'h1580, 16'h0d40, 16'h0d00), 1'b0};
				{MIF_RX, 4'd1}:
					row = {6'h0f, 16'h0000, 1'b0};
				{MIF_RX, 4'd2}:
					row = {6'h10, pick(rate, 16'h8450, 16'h8440, 16'h8440), 1'b0};
				{MIF_RX, 4'd3}:
					row = {6'h11, pick(rate, 16'h0001, 16'h0021, 16'h0021), 1'b0};
				{MIF_RX, 4'd4}:		// Last RX word
					row = {6'h12, pick(rate, 16'h1100, 16'h1100, 16'h0100), 1'b1};
				{MIF_TX, 4'd0}:		// TX clock divider
					row = {6'h00, pick(rate, 16'h052c, 16'h056c, 16'h052c), 1'b0};
				{MIF_TX, 4'd1}:		// TX slew, last TX word
					row = {6'h02, pick(rate, 16'h012c, 16'h012c, 16'h03ac), 1'b1};
				{MIF_CMU, 4'd0}:	// PMA TX PLL word 1
					row = {6'h0e, pick(rate, 16'h0e01, 16'h1401, 16'h1401), 1'b0};
				{MIF_CMU, 4'd1}:
					row = {6'h0f, 16'h0000, 1'b0};
				{MIF_CMU, 4'd2}:
					row = {6'h10, pick(rate, 16'h8450, 16'h8440, 16'h8440), 1'b0};
				{MIF_CMU, 4'd3}:
					row = {6'h11, pick(rate, 16'h4001, 16'h4021, 16'h0021), 1'b0};
				{MIF_CMU, 4'd4}:	// Same at every rate, last CMU word
					row = {6'h12, 16'h0100, 1'b1};
				default:
					row = '0;
			endcase
		end
	end
	// ***********************************************
	// Stratix V table, shared by Arria V GZ
	// ***********************************************
	else
	begin : g_stratix_v
		always_comb
		begin
			row = '0;		// Unlisted type or index
			case ({mif_type, index})
				{MIF_RX, 4'd0}:		// PMA RX PLL word 1
					row = {6'h0c, pick(rate, 16'h5600, 16'h5600, 16'h5500), 1'b0};
				{MIF_RX, 4'd1}:
					row = {6'h0d, 16'h0000, 1'b0};
				{MIF_RX, 4'd2}:
					row = {6'h0e, 16'h0d60, 1'b0};
				{MIF_RX, 4'd3}:
					row = {6'h0f, 16'h0006, 1'b0};
				{MIF_RX, 4'd4}:
					row = {6'h10, 16'h4000, 1'b0};
				{MIF_RX, 4'd5}:		// Eye monitor, last RX word
					row = {6'h16, pick(rate, 16'h0296, 16'h0496, 16'h0496), 1'b1};
				{MIF_TX, 4'd0}:		// TX clock divider
					row = {6'h00, pick(rate, 16'h2838, 16'h2a38, 16'h2838), 1'b0};
				{MIF_TX, 4'd1}:		// TX slew
					row = {6'h02, pick(rate, 16'h8094, 16'h8094, 16'h80d4), 1'b0};
				{MIF_TX, 4'd2}:		// TX common mode, last TX word
					row = {6'h04, pick(rate, 16'h06c0, 16'h03c0, 16'h03c0), 1'b1};
				{MIF_CMU, 4'd0}:	// PMA TX PLL word 1
					row = {6'h0c, pick(rate, 16'h3801, 16'h5401, 16'h5401), 1'b0};
				{MIF_CMU, 4'd1}:
					row = {6'h0d, 16'h0000, 1'b0};
				{MIF_CMU, 4'd2}:
					row = {6'h0e, 16'h0d60, 1'b0};
				{MIF_CMU, 4'd3}:
					row = {6'h0f, 16'h8006, 1'b0};
				{MIF_CMU, 4'd4}:	// Last CMU word
					row = {6'h10, 16'h4000, 1'b1};
				default:
					row = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/dp_reconfig_apb_regs.sv ====
// ***********************************************
// DisplayPort rate-change controller APB slave
// Holds mif_type and link rates, issues start
// and reads back sequencer status
// Zero wait states, no pready
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

`include "dp_reconfig_params.svh"

module dp_reconfig_apb_regs (
	input  wire							clk,
	input  wire							reset,
	input  wire							psel,
	input  wire							penable,
	input  wire							pwrite,
	input  wire [`DP_APB_ADDR_W-1:0]	paddr,
	input  wire [`DP_APB_DATA_W-1:0]	pwdata,
	output logic [`DP_APB_DATA_W-1:0]	prdata,
	output logic						pslverr,
	dp_reconfig_ctrl_if.regs			ctrl
);
	import dp_reconfig_pkg::*;

	localparam int START_BIT = 3;		// CTRL start, self clearing

	logic		access;			// APB access cycle
	logic		sel_ctrl;
	logic		sel_rate;
	logic		sel_status;
	logic		wr_ok;			// Write that takes effect
	logic		wr_start;
	mif_type_e	wr_type;		// mif_type field of pwdata
	mif_type_e	mif_type_q;
	link_rate_e	rx_rate_q;
	link_rate_e	tx_rate_q;

	assign access     = psel & penable;
	assign sel_ctrl   = (paddr == `DP_REG_CTRL);
	assign sel_rate   = (paddr == `DP_REG_RATE);
	assign sel_status = (paddr == `DP_REG_STATUS);
	assign wr_type    = mif_type_e'(pwdata[2:0]);

	// ***********************************************
	// Error response
	// ***********************************************
	always_comb
	begin
		pslverr = 1'b0;
		if (access)
		begin
			if (!(sel_ctrl | sel_rate | sel_status))
				pslverr = 1'b1;			// Hole in the map
			else if (pwrite & sel_status)
				pslverr = 1'b1;			// STATUS is read only
			else if (pwrite & sel_ctrl & pwdata[START_BIT] & ctrl.status.busy)
				pslverr = 1'b1;			// Restart during a run
		end
	end

	assign wr_ok    = access & pwrite & ~pslverr;
	assign wr_start = wr_ok & sel_ctrl & pwdata[START_BIT];

	// ***********************************************
	// Registers
	// ***********************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mif_type_q <= MIF_DUPLEX;
			rx_rate_q  <= RATE_RBR;
			tx_rate_q  <= RATE_RBR;
		end
		else if (wr_ok)
		begin
			if (sel_ctrl)
				mif_type_q <= wr_type;
			if (sel_rate)
			begin
				rx_rate_q <= link_rate_e'(pwdata[1:0]);
				tx_rate_q <= link_rate_e'(pwdata[5:4]);
			end
		end
	end

	// Sequencer samples type together with start
	assign ctrl.start        = wr_start;
	assign ctrl.mif_type     = wr_start ? wr_type : mif_type_q;
	assign ctrl.rx_link_rate = rx_rate_q;
	assign ctrl.tx_link_rate = tx_rate_q;

	// Read mux, valid in the access cycle
	always_comb
	begin
		case (paddr)
			`DP_REG_CTRL:
				prdata = {{(`DP_APB_DATA_W-3){1'b0}}, mif_type_q};		// Start reads 0
			`DP_REG_RATE:
				prdata = {{(`DP_APB_DATA_W-6){1'b0}}, tx_rate_q, 2'b00, rx_rate_q};
			`DP_REG_STATUS:
				prdata = {{(`DP_APB_DATA_W-$bits(reconfig_status_t)){1'b0}}, ctrl.status};
			default:
				prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/dp_reconfig_seq.sv ====
// ***********************************************
// DisplayPort reconfiguration sequencer
// Checks a start, then walks one MIF list (two
// for DUPLEX) and writes each word on the
// reconfiguration port with wait-request
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

`include "dp_reconfig_params.svh"

module dp_reconfig_seq (
	input  wire							clk,
	input  wire							reset,
	input  wire							mif_waitrequest,
	input  wire [`DP_MIF_OFFSET_W-1:0]	map_offset,
	input  wire [`DP_MIF_DATA_W-1:0]	map_value,
	input  wire							map_done,
	output dp_reconfig_pkg::mif_type_e	mif_type_sel,
	output logic [`DP_MIF_INDEX_W-1:0]	index,
	output logic [`DP_MIF_OFFSET_W-1:0]	mif_address,
	output logic [`DP_MIF_DATA_W-1:0]	mif_writedata,
	output logic						mif_write,
	dp_reconfig_ctrl_if.seq				ctrl
);
	import dp_reconfig_pkg::*;

	typedef enum logic [1:0]
	{
		IDLE,
		RUN_FIRST,		// RX list of DUPLEX, or the only list
		RUN_SECOND		// TX list of DUPLEX
	} state_e;

	state_e		state;
	mif_type_e	run_type;		// Type latched at start
	logic [3:0]	word_count;
	logic		done_q;
	logic		error_q;
	logic		busy;
	logic		accept;			// Word taken by the port
	logic		need_rx;
	logic		need_tx;
	logic		start_bad;

	assign busy   = (state != IDLE);
	assign accept = mif_write & ~mif_waitrequest;

	// Start validity, from the values seen with start
	assign need_rx = (ctrl.mif_type == MIF_RX) | (ctrl.mif_type == MIF_DUPLEX);
	assign need_tx = (ctrl.mif_type == MIF_TX) | (ctrl.mif_type == MIF_CMU)
		| (ctrl.mif_type == MIF_DUPLEX);
	assign start_bad = (ctrl.mif_type >= MIF_ATX)			// ATX and undefined codes
		| (need_rx & (ctrl.rx_link_rate > RATE_HBR2))		// Rate code 3
		| (need_tx & (ctrl.tx_link_rate > RATE_HBR2));

	// List fed to the table
	always_comb
	begin
		if (state == RUN_SECOND)
			mif_type_sel = MIF_TX;
		else if (run_type == MIF_DUPLEX)
			mif_type_sel = MIF_RX;		// DUPLEX opens with RX
		else
			mif_type_sel = run_type;
	end

	// ***********************************************
	// Run control
	// ***********************************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= IDLE;
			run_type   <= MIF_DUPLEX;
			index      <= '0;
			word_count <= '0;
			done_q     <= 1'b0;
			error_q    <= 1'b0;
		end
		else if (ctrl.start)
		begin
			index      <= '0;
			word_count <= '0;
			done_q     <= 1'b0;
			error_q    <= start_bad;		// Bad start never leaves IDLE
			if (!start_bad)
			begin
				state    <= RUN_FIRST;
				run_type <= ctrl.mif_type;
			end
		end
		else if (accept)
		begin
			word_count <= word_count + 1'b1;
			if (!map_done)
				index <= index + 1'b1;		// Next word of this list
			else if ((state == RUN_FIRST) && (run_type == MIF_DUPLEX))
			begin
				state <= RUN_SECOND;		// TX word 0 next cycle
				index <= '0;
			end
			else
			begin
				state  <= IDLE;
				done_q <= 1'b1;
			end
		end
	end

	// Table word goes out while busy and holds under wait-request
	assign mif_write     = busy;
	assign mif_address   = map_offset;
	assign mif_writedata = map_value;

	assign ctrl.status = '{
		word_count: word_count,
		reserved:   '0,
		error:      error_q,
		done:       done_q,
		busy:       busy
	};

endmodule

`default_nettype wire

// ==== design/dp_reconfig_top.sv ====
// ***********************************************
// DisplayPort transceiver rate-change controller
// APB register block, sequencer and MIF table
// for one channel
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

`include "dp_reconfig_params.svh"

module dp_reconfig_top #(
	parameter DEVICE_FAMILY = "Stratix V"
)(
	input  wire							clk,
	input  wire							reset,
	// APB slave
	input  wire							psel,
	input  wire							penable,
	input  wire							pwrite,
	input  wire [`DP_APB_ADDR_W-1:0]	paddr,
	input  wire [`DP_APB_DATA_W-1:0]	pwdata,
	output logic [`DP_APB_DATA_W-1:0]	prdata,
	output logic						pslverr,
	// Reconfiguration write port
	output logic [`DP_MIF_OFFSET_W-1:0]	mif_address,
	output logic [`DP_MIF_DATA_W-1:0]	mif_writedata,
	output logic						mif_write,
	input  wire							mif_waitrequest
);
	import dp_reconfig_pkg::*;

	dp_reconfig_ctrl_if ctrl_bus ();

	mif_type_e					mif_type_sel;	// List being walked
	logic [`DP_MIF_INDEX_W-1:0]	index;
	logic [`DP_MIF_OFFSET_W-1:0]	map_offset;
	logic [`DP_MIF_DATA_W-1:0]	map_value;
	logic						map_done;		// Last word of the list

	dp_reconfig_apb_regs u_regs (
		.clk		(clk),
		.reset		(reset),
		.psel		(psel),
		.penable	(penable),
		.pwrite		(pwrite),
		.paddr		(paddr),
		.pwdata		(pwdata),
		.prdata		(prdata),
		.pslverr	(pslverr),
		.ctrl		(ctrl_bus.regs)
	);

	dp_reconfig_seq u_seq (
		.clk				(clk),
		.reset				(reset),
		.mif_waitrequest	(mif_waitrequest),
		.map_offset			(map_offset),
		.map_value			(map_value),
		.map_done			(map_done),
		.mif_type_sel		(mif_type_sel),
		.index				(index),
		.mif_address		(mif_address),
		.mif_writedata		(mif_writedata),
		.mif_write			(mif_write),
		.ctrl				(ctrl_bus.seq)
	);

	// Rates come straight from the RATE register
	dp_mif_mappings #(
		.DEVICE_FAMILY	(DEVICE_FAMILY)
	) u_map (
		.mif_type		(mif_type_sel),
		.rx_link_rate	(ctrl_bus.rx_link_rate),
		.tx_link_rate	(ctrl_bus.tx_link_rate),
		.index			(index),
		.offset			(map_offset),
		.value			(map_value),
		.done			(map_done)
	);

endmodule

`default_nettype wire

// ==== verification/dp_reconfig_checker.sv ====
// ***********************************************
// DisplayPort rate-change controller checker
// Watches the reconfiguration write port, compares
// each accepted word in order and counts results
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

`include "dp_reconfig_params.svh"

module dp_reconfig_checker (
	input  wire							clk,
	input  wire							reset,
	input  wire							mif_write,
	input  wire							mif_waitrequest,
	input  wire [`DP_MIF_OFFSET_W-1:0]	mif_address,
	input  wire [`DP_MIF_DATA_W-1:0]	mif_writedata
);
	localparam int WORD_W = `DP_MIF_OFFSET_W + `DP_MIF_DATA_W;

	logic [WORD_W-1:0]	exp_q [$];				// {offset, value} still to come
	logic [WORD_W-1:0]	held_word;				// Word seen under wait-request
	logic				held = 1'b0;
	string				test_name = "none";
	int					accepted = 0;			// Words taken in this test
	int					test_errors = 0;
	int					errors = 0;				// Whole run
	int					tests_run = 0;
	int					tests_failed = 0;

	// Value check, prints on mismatch
	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
			errors++;
		end
	endtask

	// Failure that has no expected value
	task automatic note_error(input string msg);
		$display("Error in test %s: %s", test_name, msg);
		test_errors++;
		errors++;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		accepted    = 0;
		exp_q.delete();
		tests_run++;
	endtask

	task automatic expect_word(input logic [WORD_W-1:0] w);
		exp_q.push_back(w);
	endtask

	// One line per finished test
	task automatic end_test(input int exp_count);
		compare("word count", exp_count, accepted);
		if (exp_q.size() != 0)
			note_error($sformatf("%0d expected writes never arrived", exp_q.size()));
		if (test_errors == 0)
			$display("Test %s: pass", test_name);
		else
		begin
			$display("Test %s: fail with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	task automatic take_word(input logic [WORD_W-1:0] w);
		logic [WORD_W-1:0] e;
		accepted++;
		if (exp_q.size() == 0)
			note_error($sformatf("unexpected write to offset %h", w[WORD_W-1 -: `DP_MIF_OFFSET_W]));
		else
		begin
			e = exp_q.pop_front();
			compare($sformatf("word %0d", accepted - 1), e, w);	// {offset, value}
		end
	endtask

	// ***********************************************
	// Port monitor, sampled mid cycle
	// ***********************************************
	always @(negedge clk)
	begin
		if (reset)
			held = 1'b0;
		else
		begin
			if (held && !(mif_write && ({mif_address, mif_writedata} == held_word)))
				note_error("write port changed address or data under wait-request");
			held      = mif_write & mif_waitrequest;		// Stall, must hold next cycle
			held_word = {mif_address, mif_writedata};
			if (mif_write && !mif_waitrequest)
				take_word({mif_address, mif_writedata});
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_dp_reconfig.sv ====
// ***********************************************
// DisplayPort rate-change controller testbench
// APB driver, write-port responder with random
// stalls and a table of runs on Stratix V words
// ***********************************************

`timescale 1ns/100ps
`default_nettype none

`include "dp_reconfig_params.svh"

module tb_dp_reconfig;

	localparam int KIND_RX  = 0;
	localparam int KIND_TX  = 1;
	localparam int KIND_CMU = 2;
	localparam int N_TESTS  = 10;

	// Word lists, {offset, RBR, HBR, HBR2} per entry, index 0 at the bottom
	localparam logic [5:0][63:0] RX_TAB = {
		64'h0016_0296_0496_0496,	// Last RX word
		64'h0010_4000_4000_4000,
		64'h000f_0006_0006_0006,
		64'h000e_0d60_0d60_0d60,
		64'h000d_0000_0000_0000,
		64'h000c_5600_5600_5500
	};
	localparam logic [2:0][63:0] TX_TAB = {
		64'h0004_06c0_03c0_03c0,	// Last TX word
		64'h0002_8094_8094_80d4,
		64'h0000_2838_2a38_2838
	};
	localparam logic [4:0][63:0] CMU_TAB = {
		64'h0010_4000_4000_4000,	// Last CMU word
		64'h000f_8006_8006_8006,
		64'h000e_0d60_0d60_0d60,
		64'h000d_0000_0000_0000,
		64'h000c_3801_5401_5401
	};

	typedef struct {
		string		name;
		logic [2:0]	mtype;		// CTRL bits 2:0
		logic [1:0]	rx;
		logic [1:0]	tx;
		bit			stall;		// Random wait-request on
		bit			exp_err;
		int			exp_count;
	} test_t;

	test_t						tests [N_TESTS];
	logic						clk;
	logic						reset;
	logic						psel;
	logic						penable;
	logic						pwrite;
	logic [`DP_APB_ADDR_W-1:0]	paddr;
	logic [`DP_APB_DATA_W-1:0]	pwdata;
	logic [`DP_APB_DATA_W-1:0]	prdata;
	logic						pslverr;
	logic [`DP_MIF_OFFSET_W-1:0]	mif_address;
	logic [`DP_MIF_DATA_W-1:0]	mif_writedata;
	logic						mif_write;
	logic						mif_waitrequest;
	bit							stall_en = 1'b0;
	bit							new_word = 1'b1;
	int							stall_left = 0;
	bit							aborted = 1'b0;		// A wait ran out

	dp_reconfig_top #(.DEVICE_FAMILY("Stratix V")) uut (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pslverr(pslverr),
		.mif_address(mif_address), .mif_writedata(mif_writedata),
		.mif_write(mif_write), .mif_waitrequest(mif_waitrequest)
	);

	dp_reconfig_checker chk (
		.clk(clk), .reset(reset), .mif_write(mif_write), .mif_waitrequest(mif_waitrequest),
		.mif_address(mif_address), .mif_writedata(mif_writedata)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;		// 100 ns period
	end

	// Write-port responder, 0 to 3 stall cycles per word
	always @(posedge clk)
	begin
		#1;
		if (mif_write && stall_en)
		begin
			if (new_word)
			begin
				stall_left = $urandom % 4;
				new_word   = 1'b0;
			end
			if (stall_left > 0)
			begin
				mif_waitrequest = 1'b1;
				stall_left      = stall_left - 1;
			end
			else
			begin
				mif_waitrequest = 1'b0;		// Taken at the next edge
				new_word        = 1'b1;
			end
		end
		else
		begin
			mif_waitrequest = 1'b0;
			new_word        = 1'b1;
		end
	end

	// {offset, value} of word i of one list at one rate
	function automatic logic [21:0] table_word(input int kind, input int rate, input int i);
		logic [63:0] e;
		case (kind)
			KIND_RX:	e = RX_TAB[i];
			KIND_TX:	e = TX_TAB[i];
			default:	e = CMU_TAB[i];
		endcase
		return {e[53:48], e[47 - 16 * rate -: 16]};
	endfunction

	task automatic push_list(input int kind, input int rate);
		int len;
		len = (kind == KIND_RX) ? 6 : (kind == KIND_TX) ? 3 : 5;
		for (int k = 0; k < len; k++)
			chk.expect_word(table_word(kind, rate, k));
	endtask

	task automatic load_expected(input logic [2:0] mtype, input logic [1:0] rx,
		input logic [1:0] tx);
		case (mtype)
			3'd0:
			begin
				push_list(KIND_RX, rx);		// DUPLEX, RX list first
				push_list(KIND_TX, tx);
			end
			3'd1:		push_list(KIND_CMU, tx);
			3'd2:		push_list(KIND_RX, rx);
			3'd3:		push_list(KIND_TX, tx);
			default:	;
		endcase
	endtask

	// ***********************************************
	// APB driver, called a little after a rising edge
	// ***********************************************
	task automatic apb_access(input bit write, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		psel    = 1'b1;			// Setup cycle
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;			// Access cycle
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'h0, data, err);
	endtask

	// Busy falls when mif_write drops
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (mif_write && n < limit)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (mif_write)
		begin
			chk.note_error("sequencer still busy when its wait ran out");
			aborted = 1'b1;
		end
	endtask

	task automatic wait_write(input int limit);
		int n;
		n = 0;
		while (!mif_write && n < limit)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!mif_write)
		begin
			chk.note_error("no write appeared on the reconfiguration port");
			aborted = 1'b1;
		end
	endtask

	// ***********************************************
	// Main sequence
	// ***********************************************
	initial
	begin
		int unsigned	seed_draw;
		logic [31:0]	rdata;
		logic			err;
		logic [31:0]	exp_status;

		seed_draw       = $urandom(47);
		reset           = 1'b1;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		mif_waitrequest = 1'b0;

		tests[0] = '{"rx_hbr2",     3'd2, 2'd2, 2'd0, 1'b0, 1'b0, 6};
		tests[1] = '{"tx_rbr",      3'd3, 2'd0, 2'd0, 1'b1, 1'b0, 3};
		tests[2] = '{"tx_hbr",      3'd3, 2'd0, 2'd1, 1'b1, 1'b0, 3};
		tests[3] = '{"tx_hbr2",     3'd3, 2'd0, 2'd2, 1'b1, 1'b0, 3};
		tests[4] = '{"cmu_rbr",     3'd1, 2'd0, 2'd0, 1'b1, 1'b0, 5};
		tests[5] = '{"cmu_hbr",     3'd1, 2'd0, 2'd1, 1'b1, 1'b0, 5};
		tests[6] = '{"cmu_hbr2",    3'd1, 2'd0, 2'd2, 1'b1, 1'b0, 5};
		tests[7] = '{"duplex",      3'd0, 2'd1, 2'd0, 1'b1, 1'b0, 9};
		tests[8] = '{"atx",         3'd4, 2'd0, 2'd0, 1'b0, 1'b1, 0};
		tests[9] = '{"rx_bad_rate", 3'd2, 2'd3, 2'd0, 1'b0, 1'b1, 0};

		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		chk.begin_test("reset_state");
		chk.compare("mif_write", 0, mif_write);
		apb_read(`DP_REG_STATUS, rdata, err);
		chk.compare("status", 0, rdata);
		apb_read(`DP_REG_RATE, rdata, err);
		chk.compare("rate", 0, rdata);
		chk.end_test(0);

		for (int i = 0; i < N_TESTS && !aborted; i++)
		begin
			chk.begin_test(tests[i].name);
			if (!tests[i].exp_err)
				load_expected(tests[i].mtype, tests[i].rx, tests[i].tx);
			stall_en = tests[i].stall;
			apb_write(`DP_REG_RATE, {26'd0, tests[i].tx, 2'b00, tests[i].rx}, err);
			apb_write(`DP_REG_CTRL, {28'd0, 1'b1, tests[i].mtype}, err);	// Start
			chk.compare("pslverr", 0, err);
			wait_idle(200);
			// Done with word_count, or error with busy low
			exp_status = tests[i].exp_err ? 32'h4 : ((tests[i].exp_count << 8) | 32'h2);
			apb_read(`DP_REG_STATUS, rdata, err);
			chk.compare("status", exp_status, rdata);
			chk.end_test(tests[i].exp_count);
		end
		stall_en = 1'b0;

		if (!aborted)
		begin
			chk.begin_test("start_while_busy");
			push_list(KIND_CMU, 1);
			apb_write(`DP_REG_RATE, 32'h10, err);		// TX at HBR
			apb_write(`DP_REG_CTRL, 32'h9, err);		// Start CMU
			wait_write(20);
			apb_write(`DP_REG_CTRL, 32'ha, err);		// Start RX, refused
			chk.compare("pslverr", 1, err);
			wait_idle(200);
			apb_read(`DP_REG_STATUS, rdata, err);
			chk.compare("status", 32'h502, rdata);
			apb_read(`DP_REG_CTRL, rdata, err);
			chk.compare("ctrl", 32'h1, rdata);			// mif_type unchanged
			chk.end_test(5);

			chk.begin_test("apb_errors");
			apb_read(4'hc, rdata, err);					// Hole in the map
			chk.compare("pslverr unmapped", 1, err);
			apb_write(`DP_REG_STATUS, 32'h0, err);
			chk.compare("pslverr status write", 1, err);
			apb_read(`DP_REG_STATUS, rdata, err);
			chk.compare("status", 32'h502, rdata);
			chk.end_test(0);
		end

		$display("%0d tests, %0d failed, %0d errors", chk.tests_run, chk.tests_failed,
			chk.errors);
		if (chk.errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/dp_reconfig_pkg.sv
design/dp_reconfig_ctrl_if.sv
design/dp_mif_mappings.sv
design/dp_reconfig_apb_regs.sv
design/dp_reconfig_seq.sv
design/dp_reconfig_top.sv
verification/dp_reconfig_checker.sv
verification/tb_dp_reconfig.sv

// ==== Bender.yml ====
package:
  name: dp_reconfig

sources:
  - include_dirs:
      - design
    files:
      - design/dp_reconfig_pkg.sv
      - design/dp_reconfig_ctrl_if.sv
      - design/dp_mif_mappings.sv
      - design/dp_reconfig_apb_regs.sv
      - design/dp_reconfig_seq.sv
      - design/dp_reconfig_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - verification/dp_reconfig_checker.sv
      - verification/tb_dp_reconfig.sv
